/* filelist.f */
rtl/isaPkg.sv
rtl/dpPkg.sv
rtl/regFile.sv
rtl/regSelect.sv
rtl/aluUnit.sv
rtl/memSys.sv
rtl/dataPath.sv
dv/tbClock.sv
dv/dataPathChecker.sv
dv/tbDataPath.sv

/* Bender.yml */
package:
  name: datapath

sources:
  - rtl/isaPkg.sv
  - rtl/dpPkg.sv
  - rtl/regFile.sv
  - rtl/regSelect.sv
  - rtl/aluUnit.sv
  - rtl/memSys.sv
  - rtl/dataPath.sv
  - target: simulation
    files:
      - dv/tbClock.sv
      - dv/dataPathChecker.sv
      - dv/tbDataPath.sv

/* dv/tbDataPath.sv */
`timescale 1ns/1ns

module tbDataPath;
	import isaPkg::*;
	import dpPkg::*;

	logic        clock;
	logic        rstN;
	dpCtrlT      ctrl;
	logic [31:0] extData;
	logic [31:0] bus;
	logic        aluDone;
	logic        memDone;
	int          busErrors;
	int          doneErrors;
	int          timeouts;
	logic [31:0] rngState;
	logic [31:0] written [$];

	tbClock u_tbClock (.clock(clock), .rstN(rstN));

	dataPath u_dataPath (
		.clock(clock),
		.rstN(rstN),
		.ctrl(ctrl),
		.extData(extData),
		.bus(bus),
		.aluDone(aluDone),
		.memDone(memDone)
	);

	dataPathChecker u_checker (
		.clock(clock),
		.rstN(rstN),
		.ctrl(ctrl),
		.extData(extData),
		.bus(bus),
		.aluDone(aluDone),
		.memDone(memDone),
		.busErrors(busErrors),
		.doneErrors(doneErrors)
	);

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic drawRandom(output logic [31:0] v);
		rngState = xorshift32(rngState);
		v = rngState;
	endtask

	function automatic dpCtrlT srcOnly(busSrcT s);
		dpCtrlT c;
		c = '0;
		c.busSrc = s;
		return c;
	endfunction

	// One micro-operation per clock
	task automatic drive(dpCtrlT c, logic [31:0] d);
		@(posedge clock);
		ctrl <= c;
		extData <= d;
	endtask

	task automatic waitDone(bit alu);
		int  n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < 64) begin
			@(negedge clock);
			seen = alu ? aluDone : memDone;
			n++;
		end
		if (!seen) begin
			timeouts++;
			$display("Timeout: no %s done pulse within 64 cycles", alu ? "ALU" : "memory");
		end
	endtask

	task automatic regRoundTrip();
		dpCtrlT      c;
		logic [31:0] w;
		logic [31:0] v;
		drawRandom(w);
		drawRandom(v);
		c = srcOnly(srcExt);
		c.irLoad = 1'b1;
		drive(c, w);
		c = srcOnly(srcExt);
		c.rfLoad = 1'b1;
		c.gra = (v[1:0] == 2'd0);
		c.grb = (v[1:0] == 2'd1);
		c.grc = (v[1:0] >= 2'd2);
		drive(c, v);
		c.busSrc = srcRegFile;
		c.rfLoad = 1'b0;
		drive(c, '0);
	endtask

	task automatic decodeCheck();
		dpCtrlT      c;
		logic [31:0] w;
		drawRandom(w);
		c = srcOnly(srcExt);
		c.irLoad = 1'b1;
		drive(c, w);
		drive(srcOnly(srcIr), '0);
		c = srcOnly(srcRegFile);
		c.gra = 1'b1;
		drive(c, '0);
		c.gra = 1'b0;
		c.grb = 1'b1;
		drive(c, '0);
		c.grb = 1'b0;
		c.grc = 1'b1;
		drive(c, '0);
		drive(srcOnly(srcConst), '0);
	endtask

	task automatic aluRun(bit isMul);
		dpCtrlT      c;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] r;
		drawRandom(a);
		drawRandom(b);
		drawRandom(r);
		c = srcOnly(srcExt);
		c.ryLoad = 1'b1;
		drive(c, a);
		drive(srcOnly(srcRy), '0);
		c = srcOnly(srcExt);
		c.aluOp = isMul ? opMul : aluOpT'({1'b0, r[2:0]});
		c.aluStart = 1'b1;
		drive(c, b);
		drive(srcOnly(srcNone), '0);
		waitDone(1'b1);
		c = srcOnly(srcNone);
		c.rzLoad = 1'b1;
		drive(c, '0);
		c = srcOnly(srcRzLo);
		c.loLoad = isMul;
		drive(c, '0);
		c = srcOnly(srcRzHi);
		c.hiLoad = isMul;
		drive(c, '0);
		if (isMul) begin
			drive(srcOnly(srcLo), '0);
			drive(srcOnly(srcHi), '0);
		end
		drive(srcOnly(srcNone), '0);
	endtask

	task automatic memAccess(logic [31:0] addr, bit isRead);
		dpCtrlT c;
		c = srcOnly(srcExt);
		c.marLoad = 1'b1;
		drive(c, addr);
		c = srcOnly(srcNone);
		c.memRead = isRead;
		c.memWrite = !isRead;
		drive(c, '0);
		drive(srcOnly(srcNone), '0);
		waitDone(1'b0);
		drive(srcOnly(srcMdr), '0);
	endtask

	// Write, clobber MDR, read back, then revisit an older address
	task automatic memTest();
		dpCtrlT      c;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] r;
		drawRandom(a);
		drawRandom(d);
		drawRandom(r);
		c = srcOnly(srcExt);
		c.mdrLoad = 1'b1;
		drive(c, d);
		memAccess(a, 1'b0);
		written.push_back(a);
		drive(c, r);
		memAccess(a, 1'b1);
		memAccess(written[r % written.size()], 1'b1);
	endtask

	task automatic pcTest();
		dpCtrlT      c;
		logic [31:0] v;
		drawRandom(v);
		c = srcOnly(srcNone);
		c.pcInc = 1'b1;
		drive(c, '0);
		drive(c, '0);
		drive(srcOnly(srcPc), '0);
		c = srcOnly(srcExt);
		c.pcLoad = 1'b1;
		drive(c, v);
		drive(srcOnly(srcPc), '0);
		// Increment takes priority over the bus load
		c.pcInc = 1'b1;
		drive(c, ~v);
		drive(srcOnly(srcPc), '0);
	endtask

	initial begin
		int          n;
		int          total;
		logic [31:0] r;
		ctrl = '0;
		extData = '0;
		timeouts = 0;
		rngState = 32'h4c3d_d185;
		n = 0;
		while (rstN !== 1'b1 && n < 64) begin
			@(posedge clock);
			n++;
		end
		if (rstN !== 1'b1) begin
			timeouts++;
			$display("Timeout: reset was never released");
		end
		// State straight out of reset
		drive(srcOnly(srcPc), '0);
		drive(srcOnly(srcRzLo), '0);
		drive(srcOnly(srcRzHi), '0);
		drive(srcOnly(srcNone), '0);
		for (int i = 0; i < 200; i++) begin
			drawRandom(r);
			case (r % 6)
				0: regRoundTrip();
				1: decodeCheck();
				2: aluRun(1'b0);
				3: aluRun(1'b1);
				4: memTest();
				default: pcTest();
			endcase
		end
		repeat (4) drive(srcOnly(srcNone), '0);
		@(posedge clock);
		total = busErrors + doneErrors + timeouts;
		$display("Errors: bus %0d, done %0d, timeout %0d", busErrors, doneErrors, timeouts);
		if (total == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

/* dv/dataPathChecker.sv */
`timescale 1ns/1ns

module dataPathChecker (
	input  logic                     clock,
	input  logic                     rstN,
	input  dpPkg::dpCtrlT            ctrl,
	input  logic [isaPkg::wordW-1:0] extData,
	input  logic [isaPkg::wordW-1:0] bus,
	input  logic                     aluDone,
	input  logic                     memDone,
	output int                       busErrors,
	output int                       doneErrors
);
	import isaPkg::*;
	import dpPkg::*;

	logic [wordW-1:0]   regs [16];
	logic [wordW-1:0]   ram [memDepth];
	logic [wordW-1:0]   pc, ir, ry, hi, lo, mdr;
	logic [2*wordW-1:0] rz, aluRes, aluPending;
	logic [7:0]         mar, memAddr;
	logic               memIsRead, aluDoneExp, memDoneExp;
	int                 aluTimer, memTimer;

	initial begin
		busErrors = 0;
		doneErrors = 0;
	end

	// Results as the instruction set defines them, 32-bit ones sign-extended
	function automatic logic [2*wordW-1:0] aluModel(aluOpT op, logic [31:0] a, logic [31:0] b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic [31:0]        r;
		sa = $signed(a);
		sb = $signed(b);
		case (op)
			opAdd: r = a + b;
			opSub: r = a - b;
			opAnd: r = a & b;
			opOr:  r = a | b;
			opShl: r = a << b[4:0];
			opSra: r = $signed(a) >>> b[4:0];
			opNeg: r = -b;
			opNot: r = ~b;
			opMul: return sa * sb;
			default: r = '0;
		endcase
		return {{32{r[31]}}, r};
	endfunction

	// Field positions: opcode 31:27, ra 26:23, rb 22:19, rc 18:15
	function automatic logic [3:0] selIdx(logic [31:0] w, dpCtrlT c);
		if (c.gra) return w[26:23];
		if (c.grb) return w[22:19];
		if (c.grc) return w[18:15];
		return 4'd0;
	endfunction

	function automatic logic [wordW-1:0] busModel(dpCtrlT c, logic [31:0] d);
		case (c.busSrc)
			srcExt:     return d;
			srcRegFile: return regs[selIdx(ir, c)];
			srcPc:      return pc;
			srcIr:      return ir;
			srcRy:      return ry;
			srcRzLo:    return rz[31:0];
			srcRzHi:    return rz[63:32];
			srcHi:      return hi;
			srcLo:      return lo;
			srcMdr:     return mdr;
			srcConst:   return {{13{ir[18]}}, ir[18:0]};
			default:    return '0;
		endcase
	endfunction

	// Compare mid-cycle, then advance the model to the next rising edge
	always @(negedge clock) begin : step
		logic [wordW-1:0] b;
		logic [3:0]       idx;
		if (!rstN) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] = '0;
			end
			{pc, ir, ry, hi, lo, mdr} = '0;
			{rz, aluRes, aluPending} = '0;
			{mar, memAddr, memIsRead, aluDoneExp, memDoneExp} = '0;
			aluTimer = 0;
			memTimer = 0;
		end else begin
			b = busModel(ctrl, extData);
			idx = selIdx(ir, ctrl);
			if (bus !== b) begin
				busErrors++;
				$display("[FAIL] %0t ns bus: expected %h, actual %h", $time, b, bus);
			end
			if (aluDone !== aluDoneExp) begin
				doneErrors++;
				$display("[FAIL] %0t ns aluDone: expected %b, actual %b",
					$time, aluDoneExp, aluDone);
			end
			if (memDone !== memDoneExp) begin
				doneErrors++;
				$display("[FAIL] %0t ns memDone: expected %b, actual %b",
					$time, memDoneExp, memDone);
			end
			// ALU: RZ takes the result held before this edge
			aluDoneExp = (aluTimer == 1);
			if (ctrl.rzLoad) rz = aluRes;
			if (aluTimer == 1) aluRes = aluPending;
			if (aluTimer > 0) aluTimer--;
			if (ctrl.aluStart) begin
				aluPending = aluModel(ctrl.aluOp, ry, b);
				aluTimer = (ctrl.aluOp == opMul) ? mulSteps + 1 : 1;
			end
			// Memory completes two edges after the strobe
			memDoneExp = (memTimer == 1);
			if (memTimer == 1) begin
				if (memIsRead) mdr = ram[memAddr];
				else ram[memAddr] = mdr;
			end else if (ctrl.mdrLoad && memTimer == 0) begin
				mdr = b;
			end
			if (memTimer > 0) memTimer--;
			if (ctrl.memRead || ctrl.memWrite) begin
				memAddr = mar;
				memIsRead = ctrl.memRead;
				memTimer = 2;
			end
			if (ctrl.marLoad) mar = b[7:0];
			if (ctrl.rfLoad) regs[idx] = b;
			if (ctrl.pcInc) pc = pc + 1;
			else if (ctrl.pcLoad) pc = b;
			if (ctrl.irLoad) ir = b;
			if (ctrl.ryLoad) ry = b;
			if (ctrl.hiLoad) hi = b;
			if (ctrl.loLoad) lo = b;
		end
	end

endmodule

/* dv/tbClock.sv */
`timescale 1ns/1ns

module tbClock (
	output logic clock,
	output logic rstN
);
	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	// Reset held for ten rising edges, released on a falling edge
	initial begin
		rstN = 1'b0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		rstN <= 1'b1;
	end

endmodule

/* rtl/dataPath.sv */
`timescale 1ns/1ns

module dataPath (
	input  logic                     clock,
	input  logic                     rstN,
	input  dpPkg::dpCtrlT            ctrl,
	input  logic [isaPkg::wordW-1:0] extData,
	output logic [isaPkg::wordW-1:0] bus,
	output logic                     aluDone,
	output logic                     memDone
);
	import isaPkg::*;
	import dpPkg::*;

	logic [wordW-1:0]   pc;
	logic [wordW-1:0]   pcNext;
	instrU              ir;
	logic [wordW-1:0]   ry;
	logic [wordW-1:0]   hi;
	logic [wordW-1:0]   lo;
	logic [2*wordW-1:0] rz;
	logic [2*wordW-1:0] aluResult;
	regIdxT             rfIdx;
	logic [wordW-1:0]   rfData;
	logic [wordW-1:0]   constant;
	logic [wordW-1:0]   mdr;

	assign pcNext = pc + 1'b1;

	// Bus multiplexer
	always_comb begin
		case (ctrl.busSrc)
			srcExt:     bus = extData;
			srcRegFile: bus = rfData;
			srcPc:      bus = pc;
			srcIr:      bus = ir;
			srcRy:      bus = ry;
			srcRzLo:    bus = rz[wordW-1:0];
			srcRzHi:    bus = rz[2*wordW-1:wordW];
			srcHi:      bus = hi;
			srcLo:      bus = lo;
			srcMdr:     bus = mdr;
			srcConst:   bus = constant;
			default:    bus = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
			ry <= '0;
			rz <= '0;
			hi <= '0;
			lo <= '0;
		end else begin
			// Increment wins over a bus load
			if (ctrl.pcInc) begin
				pc <= pcNext;
			end else if (ctrl.pcLoad) begin
				pc <= bus;
			end
			if (ctrl.irLoad) begin
				ir <= bus;
			end
			if (ctrl.ryLoad) begin
				ry <= bus;
			end
			if (ctrl.rzLoad) begin
				rz <= aluResult;
			end
			if (ctrl.hiLoad) begin
				hi <= bus;
			end
			if (ctrl.loLoad) begin
				lo <= bus;
			end
		end
	end

	regSelect u_regSelect (
		.ir(ir),
		.gra(ctrl.gra),
		.grb(ctrl.grb),
		.grc(ctrl.grc),
		.idx(rfIdx),
		.constant(constant)
	);

	regFile u_regFile (
		.clock(clock),
		.rstN(rstN),
		.we(ctrl.rfLoad),
		.idx(rfIdx),
		.wdata(bus),
		.rdata(rfData)
	);

	// A comes from RY, B straight off the bus
	aluUnit u_aluUnit (
		.clock(clock),
		.rstN(rstN),
		.start(ctrl.aluStart),
		.op(ctrl.aluOp),
		.a(ry),
		.b(bus),
		.result(aluResult),
		.done(aluDone)
	);

	memSys u_memSys (
		.clock(clock),
		.rstN(rstN),
		.marLoad(ctrl.marLoad),
		.mdrLoad(ctrl.mdrLoad),
		.read(ctrl.memRead),
		.write(ctrl.memWrite),
		.bus(bus),
		.mdr(mdr),
		.done(memDone)
	);

endmodule

/* rtl/memSys.sv */
`timescale 1ns/1ns

module memSys (
	input  logic                     clock,
	input  logic                     rstN,
	input  logic                     marLoad,
	input  logic                     mdrLoad,
	input  logic                     read,
	input  logic                     write,
	input  logic [isaPkg::wordW-1:0] bus,
	output logic [isaPkg::wordW-1:0] mdr,
	output logic                     done
);
	import isaPkg::*;

	logic [$clog2(memDepth)-1:0] mar;
	logic [$clog2(memDepth)-1:0] memAddr;
	logic [wordW-1:0]            ram [memDepth];
	logic [1:0]                  busyPipe;
	logic                        isRead;
	logic                        busy;

	assign busy = |busyPipe;

	// Access completes on the second edge after the strobe
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			mar <= '0;
			mdr <= '0;
			busyPipe <= '0;
			isRead <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= busyPipe[1];
			busyPipe <= {busyPipe[0], read | write};
			if (marLoad) begin
				mar <= bus[$clog2(memDepth)-1:0];
			end
			if (read | write) begin
				isRead <= read;
			end
			if (busyPipe[1] && isRead) begin
				mdr <= ram[memAddr];
			end else if (mdrLoad && !busy) begin
				mdr <= bus;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (read | write) begin
			memAddr <= mar;
		end
		if (busyPipe[1] && !isRead) begin
			ram[memAddr] <= mdr;
		end
	end

	rwExclusive: assert property (
		@(posedge clock) disable iff (!rstN)
		!(read && write)
	) else $error("memory read and write strobes together");

	noStrobeWhileBusy: assert property (
		@(posedge clock) disable iff (!rstN)
		(read || write) |-> !busy
	) else $error("memory strobe while busy");

endmodule

/* rtl/aluUnit.sv */
`timescale 1ns/1ns

module aluUnit (
	input  logic                       clock,
	input  logic                       rstN,
	input  logic                       start,
	input  isaPkg::aluOpT              op,
	input  logic [isaPkg::wordW-1:0]   a,
	input  logic [isaPkg::wordW-1:0]   b,
	output logic [2*isaPkg::wordW-1:0] result,
	output logic                       done
);
	import isaPkg::*;

	aluOpT                 opR;
	logic [wordW-1:0]      opA;
	logic [wordW-1:0]      opB;
	logic [2*wordW-1:0]    mcand;
	logic [2*wordW-1:0]    acc;
	logic [$clog2(mulSteps):0] count;
	logic                  busy;
	logic [wordW-1:0]      simple;

	// One-cycle operations on the latched operands
	always_comb begin
		case (opR)
			opAdd: simple = opA + opB;
			opSub: simple = opA - opB;
			opAnd: simple = opA & opB;
			opOr:  simple = opA | opB;
			opShl: simple = opA << opB[4:0];
			opSra: simple = $signed(opA) >>> opB[4:0];
			opNeg: simple = -opB;
			opNot: simple = ~opB;
			default: simple = '0;
		endcase
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			busy <= 1'b0;
			done <= 1'b0;
			count <= '0;
			result <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				count <= '0;
			end else if (busy && opR != opMul) begin
				result <= {{wordW{simple[wordW-1]}}, simple};
				done <= 1'b1;
				busy <= 1'b0;
			end else if (busy) begin
				// All steps done, product ready in acc
				if (count == mulSteps) begin
					result <= acc;
					done <= 1'b1;
					busy <= 1'b0;
				end else begin
					count <= count + 1'b1;
				end
			end
		end
	end

	// Shift-add multiply, the sign bit of b has negative weight
	always_ff @(posedge clock) begin
		if (start) begin
			opR <= op;
			opA <= a;
			opB <= b;
			mcand <= {{wordW{a[wordW-1]}}, a};
			acc <= '0;
		end else if (busy && opR == opMul && count != mulSteps) begin
			if (opB[0]) begin
				acc <= (count == mulSteps - 1) ? acc - mcand : acc + mcand;
			end
			mcand <= mcand << 1;
			opB <= opB >> 1;
		end
	end

	noStartWhileBusy: assert property (
		@(posedge clock) disable iff (!rstN)
		start |-> !busy
	) else $error("ALU start while busy");

endmodule

/* rtl/regSelect.sv */
`timescale 1ns/1ns

module regSelect (
	input  isaPkg::instrU            ir,
	input  logic                     gra,
	input  logic                     grb,
	input  logic                     grc,
	output isaPkg::regIdxT           idx,
	output logic [isaPkg::wordW-1:0] constant
);
	import isaPkg::*;

	localparam int immW = $bits(ir.iFmt.imm);

	// ra and rb are at the same place in both views
	always_comb begin
		idx = '0;
		if (gra) begin
			idx = ir.rFmt.ra;
		end else if (grb) begin
			idx = ir.rFmt.rb;
		end else if (grc) begin
			idx = ir.rFmt.rc;
		end
	end

	// Sign-extended immediate
	assign constant = {{(wordW - immW){ir.iFmt.imm[immW-1]}}, ir.iFmt.imm};

	selOneHot: assert final ($onehot0({gra, grb, grc}))
		else $error("more than one register select strobe high");

endmodule

/* rtl/regFile.sv */
`timescale 1ns/1ns

module regFile (
	input  logic                     clock,
	input  logic                     rstN,
	input  logic                     we,
	input  isaPkg::regIdxT           idx,
	input  logic [isaPkg::wordW-1:0] wdata,
	output logic [isaPkg::wordW-1:0] rdata
);
	import isaPkg::*;

	logic [wordW-1:0] regs [2**$bits(regIdxT)];

	// Single shared index for the write and the read
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2**$bits(regIdxT); i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[idx] <= wdata;
		end
	end

	assign rdata = regs[idx];

	// A write needs a decoded index from the IR
	idxKnownOnWrite: assert property (
		@(posedge clock) disable iff (!rstN)
		we |-> !$isunknown(idx)
	) else $error("regFile write with unknown index");

endmodule

/* rtl/dpPkg.sv */
package dpPkg;

	// One code per device that may drive the bus
	typedef enum logic [3:0] {
		srcNone    = 4'd0,
		srcExt     = 4'd1,
		srcRegFile = 4'd2,
		srcPc      = 4'd3,
		srcIr      = 4'd4,
		srcRy      = 4'd5,
		srcRzLo    = 4'd6,
		srcRzHi    = 4'd7,
		srcHi      = 4'd8,
		srcLo      = 4'd9,
		srcMdr     = 4'd10,
		srcConst   = 4'd11
	} busSrcT;

	// Control word driven in from outside each cycle
	typedef struct packed {
		busSrcT        busSrc;
		logic          rfLoad;
		logic          pcLoad;
		logic          pcInc;
		logic          irLoad;
		logic          ryLoad;
		logic          rzLoad;
		logic          hiLoad;
		logic          loLoad;
		logic          marLoad;
		logic          mdrLoad;
		logic          gra;
		logic          grb;
		logic          grc;
		isaPkg::aluOpT aluOp;
		logic          aluStart;
		logic          memRead;
		logic          memWrite;
	} dpCtrlT;

endpackage

/* rtl/isaPkg.sv */
package isaPkg;

	// Architectural widths
	localparam int wordW = 32;
	localparam int memDepth = 256;
	localparam int mulSteps = 32;

	typedef logic [3:0] regIdxT;

	typedef enum logic [3:0] {
		opAdd = 4'd0,
		opSub = 4'd1,
		opAnd = 4'd2,
		opOr  = 4'd3,
		opShl = 4'd4,
		opSra = 4'd5,
		opNeg = 4'd6,
		opNot = 4'd7,
		opMul = 4'd8
	} aluOpT;

	// Three-register format
	typedef struct packed {
		logic [4:0]  opcode;
		regIdxT      ra;
		regIdxT      rb;
		regIdxT      rc;
		logic [14:0] unused;
	} rFmtT;

	// Immediate format, ra and rb sit where they do in rFmtT
	typedef struct packed {
		logic [4:0]  opcode;
		regIdxT      ra;
		regIdxT      rb;
		logic [18:0] imm;
	} iFmtT;

	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
	} instrU;

endpackage
